/* compile.f */
hdl/core_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/write_back.sv
hdl/rv_core.sv
verification/core_properties.sv
verification/core_tb.sv

/* verification/core_tb.sv */
/* core_tb: runs an assembled RV32I program on rv_core and checks every
   register write against values worked out from the ISA rules */
`timescale 1ns/100ps

module core_tb;

    logic        clk;
    logic        rst_n;
    logic        imem_en;
    logic [31:0] imem_addr, imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data, dec_pc_debug, if_pc_debug;

    logic [31:0] imem [0:255];   // 1 KiB program space
    logic        req_en;         // read accepted at the last edge
    logic [31:0] req_addr;
    logic [31:0] tbl_instr [$];  // one entry per program word
    logic        tbl_wr [$];     // entry must show up at wb_valid
    logic [4:0]  tbl_rd [$];
    logic [31:0] tbl_val [$];
    logic [31:0] model [0:31];   // expected architectural registers
    logic [31:0] pc;             // address of the next entry
    int          skip_n;         // wrong-path slots still to place
    int          mismatches, timeouts, waited;
    logic [31:0] dec_pc_hist [0:1];  // decode pc one and two cycles back
    logic [31:0] if_pc_hist [0:1];
    logic [31:0] exp_pc;             // table address of the written entry

    rv_core dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // read data lands mid-cycle in the cycle after the request
    always @(posedge clk) begin
        req_en   <= imem_en;
        req_addr <= imem_addr;
    end

    always @(negedge clk) begin
        if (req_en) imem_data <= imem[req_addr[9:2]];
    end

    // issue cycle sits two cycles before its register write
    always @(negedge clk) begin
        dec_pc_hist[0] <= dec_pc_debug;
        dec_pc_hist[1] <= dec_pc_hist[0];
        if_pc_hist[0]  <= if_pc_debug;
        if_pc_hist[1]  <= if_pc_hist[0];
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        logic lt_s;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // signed order by sign flip
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lt_s;
            3'd5:    return !lt_s;
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // wrong-path words leave the model alone and expect no write
    task automatic emit(input logic [31:0] instr, input logic [4:0] rd, input logic [31:0] val);
        tbl_instr.push_back(instr);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
        tbl_wr.push_back(rd != 5'd0 && skip_n == 0);
        if (skip_n > 0) begin
            skip_n--;
        end else if (rd != 5'd0) begin
            model[rd] = val;
        end
        pc += 32'd4;
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        emit({1'b0, alt, 5'b0, rs2, rs1, f3, rd, core_pkg::opc_op}, rd,
             alu_ref(f3, alt, model[rs1], model[rs2]));
    endtask

    task automatic op_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        emit({imm, rs1, f3, rd, core_pkg::opc_op_imm}, rd,
             alu_ref(f3, f3 == 3'd5 && imm[10], model[rs1], {{20{imm[11]}}, imm}));
    endtask

    // every transfer goes 12 bytes ahead, over two slots that write x30 and x31
    task automatic transfer(input logic [31:0] instr, input logic [4:0] rd, input logic taken);
        emit(instr, rd, pc + 32'd4);  // link value, dropped for plain branches
        skip_n = taken ? 2 : 0;
        op_ri(3'd0, 5'd30, 5'd0, 12'h5a5);
        op_ri(3'd0, 5'd31, 5'd0, 12'h3c3);
    endtask

    task automatic build_program();
        logic [19:0] u_imm;
        logic [31:0] jimm;
        pc     = 32'h0;
        skip_n = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = 32'h0;
        end
        op_ri(3'd0, 5'd1, 5'd0, 12'($urandom) | 12'h800);  // x1 negative
        op_ri(3'd0, 5'd2, 5'd0, 12'($urandom));
        for (int f = 0; f < 8; f++) begin
            op_rr(3'(f), 1'b0, 5'(3 + f), 5'd1, 5'd2);     // add .. and into x3..x10
        end
        op_rr(3'd0, 1'b1, 5'd11, 5'd1, 5'd2);             // sub
        op_rr(3'd5, 1'b1, 5'd12, 5'd1, 5'd2);             // sra
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) op_ri(3'(f), 5'(13 + f), 5'd1, 12'($urandom));
        end
        op_ri(3'd1, 5'd14, 5'd1, {7'h00, 5'($urandom)});  // slli
        op_ri(3'd5, 5'd18, 5'd1, {7'h00, 5'($urandom)});  // srli
        op_ri(3'd5, 5'd21, 5'd1, {7'h20, 5'($urandom)});  // srai
        op_ri(3'd0, 5'd22, 5'd1, 12'($urandom));          // chain, each reads the last rd
        op_rr(3'd0, 1'b0, 5'd22, 5'd22, 5'd2);
        op_rr(3'd4, 1'b0, 5'd23, 5'd22, 5'd1);
        op_rr(3'd0, 1'b1, 5'd24, 5'd23, 5'd22);
        op_ri(3'd5, 5'd24, 5'd24, 12'h403);               // srai by 3
        u_imm = 20'($urandom);
        emit({u_imm, 5'd25, core_pkg::opc_lui}, 5'd25, {u_imm, 12'h0});
        u_imm = 20'($urandom);
        emit({u_imm, 5'd26, core_pkg::opc_auipc}, 5'd26, pc + {u_imm, 12'h0});
        transfer({7'd0, 5'd1, 5'd1, 3'd0, 5'b01100, core_pkg::opc_branch}, 5'd0, 1'b1);
        transfer({7'd0, 5'd1, 5'd1, 3'd1, 5'b01100, core_pkg::opc_branch}, 5'd0, 1'b0);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                transfer({7'd0, 5'd2, 5'd1, 3'(f), 5'b01100, core_pkg::opc_branch}, 5'd0,
                         taken_ref(3'(f), model[1], model[2]));
            end
        end
        transfer({1'b0, 10'd6, 1'b0, 8'd0, 5'd27, core_pkg::opc_jal}, 5'd27, 1'b1);
        op_ri(3'd0, 5'd28, 5'd0, 12'h006);
        jimm = pc + 32'd13 - model[28];                   // odd sum, bit 0 dropped
        transfer({jimm[11:0], 5'd28, 3'd0, 5'd29, core_pkg::opc_jalr}, 5'd29, 1'b1);
        op_rr(3'd0, 1'b0, 5'd3, 5'd27, 5'd29);            // both link values
        op_ri(3'd0, 5'd0, 5'd1, 12'h123);                 // x0 targets
        op_rr(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
        op_rr(3'd0, 1'b0, 5'd4, 5'd0, 5'd1);
        op_ri(3'd4, 5'd5, 5'd0, 12'h0ff);
        emit({1'b0, 10'd0, 1'b0, 8'd0, 5'd0, core_pkg::opc_jal}, 5'd0, 32'h0);  // park
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_data  = 32'h0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(45));
        build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < tbl_instr.size()) ? tbl_instr[i] : {i[24:0], 7'h00};  // opcode 0, no-op
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < tbl_instr.size() && timeouts == 0; k++) begin
            if (tbl_wr[k]) begin
                waited = 0;
                exp_pc = 32'(k) << 2;  // entries sit in order from address zero
                @(negedge clk);
                while (!wb_valid && waited < 50) begin
                    @(negedge clk);
                    waited++;
                end
                assert (wb_valid) else begin
                    $display("timeout: no register write within 50 cycles for entry %0d", k);
                    timeouts++;
                end
                if (wb_valid) begin
                    assert (wb_rd == tbl_rd[k]) else begin
                        $display("MISMATCH wb_rd: got 0x%02h, expected 0x%02h (entry %0d)",
                                 wb_rd, tbl_rd[k], k);
                        mismatches++;
                    end
                    assert (wb_data == tbl_val[k]) else begin
                        $display("MISMATCH wb_data: got 0x%08h, expected 0x%08h (entry %0d)",
                                 wb_data, tbl_val[k], k);
                        mismatches++;
                    end
                    assert (dec_pc_hist[1] == exp_pc) else begin
                        $display("MISMATCH dec_pc_debug: got 0x%08h, expected 0x%08h (entry %0d)",
                                 dec_pc_hist[1], exp_pc, k);
                        mismatches++;
                    end
                    assert (if_pc_hist[1] == exp_pc) else begin
                        $display("MISMATCH if_pc_debug: got 0x%08h, expected 0x%08h (entry %0d)",
                                 if_pc_hist[1], exp_pc, k);
                        mismatches++;
                    end
                end
            end
        end
        for (int c = 0; c < 20 && timeouts == 0; c++) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                $display("unexpected register write to x%0d after the program ended", wb_rd);
                mismatches++;
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, dut.core_checks.prop_failures);
        if (mismatches + timeouts + dut.core_checks.prop_failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verification/core_properties.sv */
/* core_properties: concurrent checks on the issue, done, writeback and
   reset behaviour of rv_core's strobes */
`timescale 1ns/100ps

module core_properties (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            imem_en,
    input logic                            if_valid,
    input logic                            alu_issue,
    input logic                            branch_issue,
    input logic                            alu_done,
    input logic                            br_done,
    input logic                            redirect,
    input logic                            wb_valid,
    input logic [core_pkg::REG_ADDR_W-1:0] alu_rd,
    input logic [core_pkg::REG_ADDR_W-1:0] br_rd
);

    int prop_failures = 0;  // failed assertions so far

    issue_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
            !(alu_issue && branch_issue))
        else begin
            $error("alu_issue and branch_issue high together");
            prop_failures++;
        end

    alu_done_next: assert property (@(posedge clk) disable iff (!rst_n)
            alu_issue |=> alu_done)
        else begin
            $error("alu_done missing one cycle after alu_issue");
            prop_failures++;
        end

    br_done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
            br_done |-> $past(branch_issue))  // jumps only, never unprompted
        else begin
            $error("br_done without a branch_issue in the previous cycle");
            prop_failures++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
            ((alu_issue && alu_rd == '0) || (branch_issue && br_rd == '0)) |=> !wb_valid)
        else begin
            $error("wb_valid raised for an instruction that targets x0");
            prop_failures++;
        end

    quiet_in_reset: assert property (@(posedge clk)
            !rst_n |-> !(imem_en || if_valid || alu_issue || branch_issue ||
                         alu_done || br_done || redirect || wb_valid))
        else begin
            $error("control strobe high while reset is asserted");
            prop_failures++;
        end

endmodule

bind rv_core core_properties core_checks (.*);

/* hdl/rv_core.sv */
/* rv_core: in-order RV32I integer core, fetch, decode, register file,
   alu and branch units and the writeback mux */
`timescale 1ns/100ps

module rv_core (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           imem_en,
    output logic [core_pkg::XLEN-1:0]       imem_addr,
    input  logic [core_pkg::XLEN-1:0]       imem_data,
    output logic                           wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic [core_pkg::XLEN-1:0]       dec_pc_debug,
    output logic [core_pkg::XLEN-1:0]       if_pc_debug
);

    // fetch and decode
    logic                            dec_stall;
    logic                            if_valid;
    logic [core_pkg::XLEN-1:0]       if_pc, if_instr, dec_pc;
    logic                            redirect;
    logic [core_pkg::XLEN-1:0]       redirect_pc;

    // register file ports
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data, rs2_data;
    logic                            rf_we;
    logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [core_pkg::XLEN-1:0]       rf_wdata;

    // alu issue and completion
    logic                            alu_issue, alu_done;
    core_pkg::alu_op_t               alu_op;
    logic [core_pkg::XLEN-1:0]       alu_a, alu_b, alu_result;
    logic [core_pkg::REG_ADDR_W-1:0] alu_rd, alu_wb_rd;

    // branch issue and completion
    logic                            branch_issue, br_done;
    core_pkg::branch_op_t            branch_op;
    logic [core_pkg::XLEN-1:0]       br_rs1, br_rs2, br_pc, br_imm, br_result;
    logic [core_pkg::REG_ADDR_W-1:0] br_rd, br_wb_rd;

    assign if_pc_debug  = if_pc;
    assign dec_pc_debug = dec_pc;
    assign wb_valid     = rf_we;     // observation taps on the rf write
    assign wb_rd        = rf_waddr;
    assign wb_data      = rf_wdata;

    fetch fetch_block (.*);

    decode decode_block (.*);
    register_file register_file_block (.*);

    alu_unit alu_unit_block (.*);
    branch_unit branch_unit_block (.*);

    write_back write_back_mux (.*);

endmodule

/* hdl/write_back.sv */
/* write_back: picks the completing unit's result and drives the register
   file write, with writes to x0 dropped */
`timescale 1ns/100ps

module write_back (
    input  logic                           alu_done,
    input  logic [core_pkg::REG_ADDR_W-1:0] alu_wb_rd,
    input  logic [core_pkg::XLEN-1:0]       alu_result,
    input  logic                           br_done,
    input  logic [core_pkg::REG_ADDR_W-1:0] br_wb_rd,
    input  logic [core_pkg::XLEN-1:0]       br_result,
    output logic                           rf_we,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [core_pkg::XLEN-1:0]       rf_wdata
);

    // single issue keeps the two done pulses apart
    assign rf_waddr = alu_done ? alu_wb_rd : br_wb_rd;
    assign rf_wdata = alu_done ? alu_result : br_result;
    assign rf_we    = (alu_done | br_done) & (rf_waddr != '0);  // x0 masked

endmodule

/* hdl/branch_unit.sv */
/* branch_unit: resolves conditional branches and jumps, redirects fetch in
   the issue cycle and returns the link value for jal and jalr */
`timescale 1ns/100ps

module branch_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           branch_issue,
    input  core_pkg::branch_op_t           branch_op,
    input  logic [core_pkg::XLEN-1:0]       br_rs1,
    input  logic [core_pkg::XLEN-1:0]       br_rs2,
    input  logic [core_pkg::XLEN-1:0]       br_pc,
    input  logic [core_pkg::XLEN-1:0]       br_imm,
    input  logic [core_pkg::REG_ADDR_W-1:0] br_rd,
    output logic                           redirect,
    output logic [core_pkg::XLEN-1:0]       redirect_pc,
    output logic                           br_done,
    output logic [core_pkg::REG_ADDR_W-1:0] br_wb_rd,
    output logic [core_pkg::XLEN-1:0]       br_result
);

    logic                      taken;
    logic                      is_jump;
    logic [core_pkg::XLEN-1:0] jalr_sum;

    assign is_jump = (branch_op == core_pkg::br_jal) || (branch_op == core_pkg::br_jalr);

    always_comb begin
        case (branch_op)
            core_pkg::br_beq:  taken = (br_rs1 == br_rs2);
            core_pkg::br_bne:  taken = (br_rs1 != br_rs2);
            core_pkg::br_blt:  taken = ($signed(br_rs1) < $signed(br_rs2));
            core_pkg::br_bge:  taken = ($signed(br_rs1) >= $signed(br_rs2));
            core_pkg::br_bltu: taken = (br_rs1 < br_rs2);
            core_pkg::br_bgeu: taken = (br_rs1 >= br_rs2);
            default:           taken = 1'b1;  // jal, jalr
        endcase
    end

    assign jalr_sum    = br_rs1 + br_imm;
    assign redirect    = branch_issue & taken;  // one-cycle, follows issue pulse
    assign redirect_pc = (branch_op == core_pkg::br_jalr) ? {jalr_sum[31:1], 1'b0}
                                                          : br_pc + br_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_done <= 1'b0;
        end else begin
            br_done <= branch_issue & is_jump;  // only jumps write a link
        end
    end

    always_ff @(posedge clk) begin
        if (branch_issue) begin
            br_wb_rd  <= br_rd;
            br_result <= br_pc + 32'd4;
        end
    end

endmodule

/* hdl/alu_unit.sv */
/* alu_unit: single-cycle integer ALU, result registered with its rd tag
   and a done pulse one cycle after issue */
`timescale 1ns/100ps

module alu_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alu_issue,
    input  core_pkg::alu_op_t              alu_op,
    input  logic [core_pkg::XLEN-1:0]       alu_a,
    input  logic [core_pkg::XLEN-1:0]       alu_b,
    input  logic [core_pkg::REG_ADDR_W-1:0] alu_rd,
    output logic                           alu_done,
    output logic [core_pkg::REG_ADDR_W-1:0] alu_wb_rd,
    output logic [core_pkg::XLEN-1:0]       alu_result
);

    logic [core_pkg::XLEN-1:0] result;
    logic [4:0]                shamt;

    assign shamt = alu_b[4:0];  // only low five bits shift

    always_comb begin
        case (alu_op)
            core_pkg::alu_add:  result = alu_a + alu_b;
            core_pkg::alu_sub:  result = alu_a - alu_b;
            core_pkg::alu_sll:  result = alu_a << shamt;
            core_pkg::alu_slt:  result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::alu_sltu: result = {31'b0, alu_a < alu_b};
            core_pkg::alu_xor:  result = alu_a ^ alu_b;
            core_pkg::alu_srl:  result = alu_a >> shamt;
            core_pkg::alu_sra:  result = $unsigned($signed(alu_a) >>> shamt);
            core_pkg::alu_or:   result = alu_a | alu_b;
            default:            result = alu_a & alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_wb_rd  <= alu_rd;
            alu_result <= result;
        end
    end

endmodule

/* hdl/register_file.sv */
/* register_file: x1..x31 with two combinational read ports, x0 reads zero
   and a same-cycle write is bypassed to the readers */
`timescale 1ns/100ps

module register_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pkg::XLEN-1:0]       rs2_data,
    input  logic                           rf_we,
    input  logic [core_pkg::REG_ADDR_W-1:0] rf_waddr,
    input  logic [core_pkg::XLEN-1:0]       rf_wdata
);

    logic [core_pkg::XLEN-1:0] regs [1:31];  // x0 not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    always_comb begin
        if (rs1_addr == '0)                          rs1_data = '0;
        else if (rf_we && rf_waddr == rs1_addr)      rs1_data = rf_wdata;  // write-first
        else                                         rs1_data = regs[rs1_addr];
        if (rs2_addr == '0)                          rs2_data = '0;
        else if (rf_we && rf_waddr == rs2_addr)      rs2_data = rf_wdata;
        else                                         rs2_data = regs[rs2_addr];
    end

endmodule

/* hdl/decode.sv */
/* decode: splits each instruction, builds immediates and operands, stalls one
   cycle on a back-to-back dependency and issues to the alu or branch unit */
`timescale 1ns/100ps

module decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           if_valid,
    input  logic [core_pkg::XLEN-1:0]       if_pc,
    input  logic [core_pkg::XLEN-1:0]       if_instr,
    input  logic                           redirect,
    output logic                           dec_stall,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [core_pkg::XLEN-1:0]       rs1_data,
    input  logic [core_pkg::XLEN-1:0]       rs2_data,
    output logic                           alu_issue,
    output core_pkg::alu_op_t              alu_op,
    output logic [core_pkg::XLEN-1:0]       alu_a,
    output logic [core_pkg::XLEN-1:0]       alu_b,
    output logic [core_pkg::REG_ADDR_W-1:0] alu_rd,
    output logic                           branch_issue,
    output core_pkg::branch_op_t           branch_op,
    output logic [core_pkg::XLEN-1:0]       br_rs1,
    output logic [core_pkg::XLEN-1:0]       br_rs2,
    output logic [core_pkg::XLEN-1:0]       br_pc,
    output logic [core_pkg::XLEN-1:0]       br_imm,
    output logic [core_pkg::REG_ADDR_W-1:0] br_rd,
    output logic [core_pkg::XLEN-1:0]       dec_pc
);

    core_pkg::opcode_t                opcode;
    logic [2:0]                       funct3;
    logic [core_pkg::REG_ADDR_W-1:0]  rd;
    logic [core_pkg::XLEN-1:0]        imm_i, imm_b, imm_u, imm_j;
    logic                             is_alu, is_br, uses_rs1, uses_rs2;
    core_pkg::alu_op_t                op_alu;
    core_pkg::branch_op_t             op_br;
    logic [core_pkg::XLEN-1:0]        opnd_a, opnd_b, imm_br;
    logic [core_pkg::REG_ADDR_W-1:0]  rd_br;
    logic [core_pkg::REG_ADDR_W-1:0]  last_rd;
    logic                             hazard, issue_ok;

    assign opcode   = core_pkg::opcode_t'(if_instr[6:0]);
    assign funct3   = if_instr[14:12];
    assign rd       = if_instr[11:7];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];
    assign dec_pc   = if_pc;

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_u = {if_instr[31:12], 12'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    always_comb begin
        is_alu   = 1'b0;
        is_br    = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        opnd_a   = rs1_data;
        opnd_b   = rs2_data;
        imm_br   = imm_b;
        rd_br    = '0;                            // plain branches write nothing
        op_br    = core_pkg::branch_op_t'(funct3);
        case (funct3)                             // shared by op and op_imm
            3'b000:  op_alu = (opcode == core_pkg::opc_op && if_instr[30]) ?
                              core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  op_alu = core_pkg::alu_sll;
            3'b010:  op_alu = core_pkg::alu_slt;
            3'b011:  op_alu = core_pkg::alu_sltu;
            3'b100:  op_alu = core_pkg::alu_xor;
            3'b101:  op_alu = if_instr[30] ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  op_alu = core_pkg::alu_or;
            default: op_alu = core_pkg::alu_and;
        endcase
        case (opcode)
            core_pkg::opc_op: begin
                is_alu   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            core_pkg::opc_op_imm: begin
                is_alu   = 1'b1;
                uses_rs1 = 1'b1;
                opnd_b   = imm_i;
            end
            core_pkg::opc_lui: begin
                is_alu = 1'b1;
                op_alu = core_pkg::alu_add;       // 0 + imm_u
                opnd_a = '0;
                opnd_b = imm_u;
            end
            core_pkg::opc_auipc: begin
                is_alu = 1'b1;
                op_alu = core_pkg::alu_add;       // pc + imm_u
                opnd_a = if_pc;
                opnd_b = imm_u;
            end
            core_pkg::opc_branch: begin
                is_br    = (funct3[2:1] != 2'b01); // 010/011 illegal, no-op
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            core_pkg::opc_jal: begin
                is_br  = 1'b1;
                op_br  = core_pkg::br_jal;
                imm_br = imm_j;
                rd_br  = rd;
            end
            core_pkg::opc_jalr: begin
                is_br    = 1'b1;
                uses_rs1 = 1'b1;
                op_br    = core_pkg::br_jalr;
                imm_br   = imm_i;
                rd_br    = rd;
            end
            default: ;                            // unknown opcode, no-op
        endcase
    end

    // rd of whatever issued last cycle, zero when nothing writes
    assign last_rd = alu_issue ? alu_rd : (branch_issue ? br_rd : '0);
    assign hazard  = (uses_rs1 && rs1_addr != '0 && rs1_addr == last_rd) ||
                     (uses_rs2 && rs2_addr != '0 && rs2_addr == last_rd);

    assign dec_stall = if_valid & ~redirect & hazard;   // wrong-path instr never stalls
    assign issue_ok  = if_valid & ~redirect & ~hazard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_issue    <= 1'b0;
            branch_issue <= 1'b0;
        end else begin
            alu_issue    <= issue_ok & is_alu;
            branch_issue <= issue_ok & is_br;
        end
    end

    always_ff @(posedge clk) begin
        alu_op    <= op_alu;
        alu_a     <= opnd_a;
        alu_b     <= opnd_b;
        alu_rd    <= rd;
        branch_op <= op_br;
        br_rs1    <= rs1_data;
        br_rs2    <= rs2_data;
        br_pc     <= if_pc;
        br_imm    <= imm_br;
        br_rd     <= rd_br;
    end

endmodule

/* hdl/fetch.sv */
/* fetch: PC register and instruction-memory request, holds the fetched
   instruction while decode stalls and squashes the read in flight on redirect */
`timescale 1ns/100ps

module fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dec_stall,
    input  logic                     redirect,
    input  logic [core_pkg::XLEN-1:0] redirect_pc,
    output logic                     imem_en,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    input  logic [core_pkg::XLEN-1:0] imem_data,
    output logic                     if_valid,
    output logic [core_pkg::XLEN-1:0] if_pc,
    output logic [core_pkg::XLEN-1:0] if_instr
);

    logic                      running;  // set once out of reset
    logic [core_pkg::XLEN-1:0] pc;       // next address to read
    logic                      pend;     // read data arrives this cycle
    logic                      squash;   // that read is wrong-path
    logic                      hold;     // replay held instr after a stall
    logic [core_pkg::XLEN-1:0] req_pc;   // address of the returning read
    logic [core_pkg::XLEN-1:0] instr_q;  // copy of the presented instr

    assign imem_en   = running & ~dec_stall;  // no new read while decode holds
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            pc      <= core_pkg::RESET_PC;
            pend    <= 1'b0;
            squash  <= 1'b0;
            hold    <= 1'b0;
        end else begin
            running <= 1'b1;
            pend    <= imem_en;
            squash  <= redirect;              // kill read issued with redirect
            hold    <= if_valid & dec_stall;
            if (redirect) begin
                pc <= redirect_pc;            // redirect wins over advance
            end else if (imem_en) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_en) begin
            req_pc <= pc;
        end
        instr_q <= if_instr;  // keeps the stalled instr stable
    end

    assign if_valid = (pend & ~squash) | hold;
    assign if_pc    = req_pc;
    assign if_instr = pend ? imem_data : instr_q;  // fresh data or replay

endmodule

/* hdl/core_pkg.sv */
/* core_pkg: shared widths, reset PC and the opcode and unit-op encodings
   of the RV32I integer core */
package core_pkg;

    localparam int XLEN       = 32;     // data and address width
    localparam int REG_ADDR_W = 5;      // x0..x31
    localparam logic [XLEN-1:0] RESET_PC = '0;  // first fetch address

    // integer alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // conditional codes follow funct3, jumps fill the unused 010/011 slots
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_jal  = 3'b010,
        br_jalr = 3'b011,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_op_t;

    // major opcodes handled by this core, anything else is a no-op
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

endpackage
